// File: include/tiling_defs.svh
`ifndef TILING_DEFS_SVH
`define TILING_DEFS_SVH

// mapping_param fields
`define tl_map_m_hi   25
`define tl_map_m_lo   16
`define tl_map_q_hi   8
`define tl_map_q_lo   6
`define tl_map_r_hi   5
`define tl_map_r_lo   3

// shape_param1 fields
`define tl_sh_pad_hi  28
`define tl_sh_pad_lo  26
`define tl_sh_u_hi    25
`define tl_sh_u_lo    24
`define tl_sh_r_hi    23
`define tl_sh_r_lo    22
`define tl_sh_s_hi    21
`define tl_sh_s_lo    20
`define tl_sh_c_hi    19
`define tl_sh_c_lo    10
`define tl_sh_m_hi    9
`define tl_sh_m_lo    0

// shape_param2 fields, unpadded plane size
`define tl_sh_w_hi    15
`define tl_sh_w_lo    8
`define tl_sh_h_hi    7
`define tl_sh_h_lo    0

`endif

// File: logic/tiling_pkg.sv
package tiling_pkg;

    localparam int addr_width = 32;  // byte addresses on both memories
    localparam int word_width = 32;
    localparam int dim_width  = 16;  // sizes and loop indices

    // glb byte enables
    localparam logic [3:0] strobe_byte = 4'b0001;
    localparam logic [3:0] strobe_word = 4'b1111;

    // read/write pairs copy one element, the drain takes four steps per word
    typedef enum logic [3:0] {
        idle,
        ifmap_read,
        ifmap_write,
        filter_read,
        filter_write,
        bias_read,
        bias_write,
        opsum_read,
        opsum_wait,
        opsum_write,
        opsum_clear,
        pass_end
    } phase_t;

endpackage

// File: logic/shape_decode.sv
`timescale 1ns/1ps

`include "tiling_defs.svh"

module shape_decode import tiling_pkg::*; (
    input  logic [31:0]          mapping_param,
    input  logic [31:0]          shape_param1,
    input  logic [31:0]          shape_param2,
    output logic [dim_width-1:0] pad_w,
    output logic [dim_width-1:0] pad_h,
    output logic [dim_width-1:0] ch_group,
    output logic [dim_width-1:0] num_ch,
    output logic [dim_width-1:0] num_filt,
    output logic [dim_width-1:0] filt_h,
    output logic [dim_width-1:0] filt_w,
    output logic [dim_width-1:0] out_h,
    output logic [dim_width-1:0] out_w
);
    logic [dim_width-1:0] q;
    logic [dim_width-1:0] r;
    logic [dim_width-1:0] pad;
    logic [dim_width-1:0] stride;
    logic [dim_width-1:0] in_w;  // unpadded
    logic [dim_width-1:0] in_h;

    always_comb begin
        q        = dim_width'(mapping_param[`tl_map_q_hi:`tl_map_q_lo]);
        r        = dim_width'(mapping_param[`tl_map_r_hi:`tl_map_r_lo]);
        pad      = dim_width'(shape_param1[`tl_sh_pad_hi:`tl_sh_pad_lo]);
        stride   = dim_width'(shape_param1[`tl_sh_u_hi:`tl_sh_u_lo]);
        filt_h   = dim_width'(shape_param1[`tl_sh_r_hi:`tl_sh_r_lo]);
        filt_w   = dim_width'(shape_param1[`tl_sh_s_hi:`tl_sh_s_lo]);
        num_ch   = dim_width'(shape_param1[`tl_sh_c_hi:`tl_sh_c_lo]);
        num_filt = dim_width'(shape_param1[`tl_sh_m_hi:`tl_sh_m_lo]);
        in_w     = dim_width'(shape_param2[`tl_sh_w_hi:`tl_sh_w_lo]);
        in_h     = dim_width'(shape_param2[`tl_sh_h_hi:`tl_sh_h_lo]);

        ch_group = q * r;
        pad_w    = in_w + (pad << 1);
        pad_h    = in_h + (pad << 1);
        // padded size minus filter equals in - filt + 2*pad
        out_w    = (pad_w - filt_w) / stride + 1'b1;
        out_h    = (pad_h - filt_h) / stride + 1'b1;
    end

endmodule

// File: logic/index_walker.sv
`timescale 1ns/1ps

module index_walker import tiling_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  phase_t               phase,
    input  logic                 step,
    input  logic [dim_width-1:0] group_base,
    input  logic [dim_width-1:0] pad_w,
    input  logic [dim_width-1:0] pad_h,
    input  logic [dim_width-1:0] ch_group,
    input  logic [dim_width-1:0] num_filt,
    input  logic [dim_width-1:0] filt_h,
    input  logic [dim_width-1:0] filt_w,
    input  logic [dim_width-1:0] out_h,
    input  logic [dim_width-1:0] out_w,
    output logic [dim_width-1:0] row,
    output logic [dim_width-1:0] col,
    output logic [dim_width-1:0] ch,
    output logic [dim_width-1:0] filt,
    output logic                 last
);
    logic [dim_width-1:0] ch_off;  // channel within the group
    logic [dim_width-1:0] row_lim;
    logic [dim_width-1:0] col_lim;
    logic                 is_ifmap;
    logic                 is_filter;
    logic                 is_bias;
    logic                 is_opsum;
    logic                 ch_wrap;
    logic                 col_wrap;
    logic                 row_wrap;
    logic                 filt_wrap;

    assign is_ifmap  = phase inside {ifmap_read, ifmap_write};
    assign is_filter = phase inside {filter_read, filter_write};
    assign is_bias   = phase inside {bias_read, bias_write};
    assign is_opsum  = phase inside {opsum_read, opsum_wait, opsum_write, opsum_clear};

    always_comb begin
        row_lim = out_h;  // opsum plane unless loading
        col_lim = out_w;
        if (is_ifmap) begin
            row_lim = pad_h;
            col_lim = pad_w;
        end else if (is_filter) begin
            row_lim = filt_h;
            col_lim = filt_w;
        end
    end

    assign ch_wrap   = ch_off == ch_group - 1'b1;
    assign col_wrap  = col == col_lim - 1'b1;
    assign row_wrap  = row == row_lim - 1'b1;
    assign filt_wrap = filt == num_filt - 1'b1;

    always_comb begin
        last = 1'b0;
        if (is_ifmap)
            last = ch_wrap && col_wrap && row_wrap;
        else if (is_filter)
            last = ch_wrap && col_wrap && row_wrap && filt_wrap;
        else if (is_bias)
            last = filt_wrap;
        else if (is_opsum)
            last = filt_wrap && col_wrap && row_wrap;
    end

    // counters return to zero after the final element, ready for the next phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row    <= '0;
            col    <= '0;
            ch_off <= '0;
            filt   <= '0;
        end else if (step) begin
            if (last) begin
                row    <= '0;
                col    <= '0;
                ch_off <= '0;
                filt   <= '0;
            end else if (is_bias) begin
                filt <= filt + 1'b1;
            end else if (is_opsum) begin
                if (!filt_wrap) begin
                    filt <= filt + 1'b1;  // filter innermost
                end else begin
                    filt <= '0;
                    if (!col_wrap) begin
                        col <= col + 1'b1;
                    end else begin
                        col <= '0;
                        row <= row + 1'b1;
                    end
                end
            end else if (!ch_wrap) begin
                ch_off <= ch_off + 1'b1;  // ifmap and filter, channel innermost
            end else begin
                ch_off <= '0;
                if (!col_wrap) begin
                    col <= col + 1'b1;
                end else begin
                    col <= '0;
                    if (!row_wrap) begin
                        row <= row + 1'b1;
                    end else begin
                        row  <= '0;
                        filt <= filt + 1'b1;  // only reached in the filter phase
                    end
                end
            end
        end
    end

    assign ch = group_base + ch_off;

endmodule

// File: logic/addr_calc.sv
`timescale 1ns/1ps

module addr_calc import tiling_pkg::*; (
    input  phase_t                phase,
    input  logic [dim_width-1:0]  row,
    input  logic [dim_width-1:0]  col,
    input  logic [dim_width-1:0]  ch,
    input  logic [dim_width-1:0]  filt,
    input  logic [dim_width-1:0]  group_base,
    input  logic [dim_width-1:0]  pad_w,
    input  logic [dim_width-1:0]  ch_group,
    input  logic [dim_width-1:0]  num_ch,
    input  logic [dim_width-1:0]  num_filt,
    input  logic [dim_width-1:0]  filt_h,
    input  logic [dim_width-1:0]  filt_w,
    input  logic [dim_width-1:0]  out_w,
    input  logic [addr_width-1:0] dram_ifmap_base_addr,
    input  logic [addr_width-1:0] dram_filter_base_addr,
    input  logic [addr_width-1:0] dram_bias_base_addr,
    input  logic [addr_width-1:0] dram_opsum_base_addr,
    input  logic [addr_width-1:0] glb_ifmap_base_addr,
    input  logic [addr_width-1:0] glb_filter_base_addr,
    input  logic [addr_width-1:0] glb_bias_base_addr,
    input  logic [addr_width-1:0] glb_opsum_base_addr,
    output logic [addr_width-1:0] dram_addr_next,
    output logic [addr_width-1:0] glb_addr_next
);
    logic [dim_width-1:0]  ch_off;
    logic [addr_width-1:0] ifmap_pos;   // glb holds one group, dense in visiting order
    logic [addr_width-1:0] filter_pos;
    logic [addr_width-1:0] opsum_off;   // same layout on both sides

    always_comb begin
        ch_off     = ch - group_base;
        ifmap_pos  = (row * pad_w + col) * ch_group + ch_off;
        filter_pos = ((filt * filt_h + row) * filt_w + col) * ch_group + ch_off;
        opsum_off  = ((row * out_w + col) * num_filt + filt) * 4;

        dram_addr_next = '0;
        glb_addr_next  = '0;
        case (phase)
            ifmap_read, ifmap_write: begin
                dram_addr_next = dram_ifmap_base_addr + (row * pad_w + col) * num_ch + ch;
                glb_addr_next  = glb_ifmap_base_addr + ifmap_pos;
            end
            filter_read, filter_write: begin
                dram_addr_next = dram_filter_base_addr
                               + (row * filt_w + col) * num_ch * num_filt
                               + ch * num_filt + filt;
                glb_addr_next  = glb_filter_base_addr + filter_pos;
            end
            bias_read, bias_write: begin
                dram_addr_next = dram_bias_base_addr + filt * 4;  // 32-bit biases
                glb_addr_next  = glb_bias_base_addr + filt * 4;
            end
            opsum_read, opsum_wait, opsum_write, opsum_clear: begin
                dram_addr_next = dram_opsum_base_addr + opsum_off;
                glb_addr_next  = glb_opsum_base_addr + opsum_off;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/tile_fsm.sv
`timescale 1ns/1ps

module tile_fsm import tiling_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  last,
    input  logic [dim_width-1:0]  num_ch,
    input  logic [dim_width-1:0]  ch_group,
    input  logic [addr_width-1:0] dram_addr_next,
    input  logic [addr_width-1:0] glb_addr_next,
    input  logic [word_width-1:0] dram_r_data,
    input  logic [word_width-1:0] glb_r_data,
    output phase_t                phase,
    output logic                  step,
    output logic [dim_width-1:0]  group_base,
    output logic                  dram_we,
    output logic [addr_width-1:0] dram_addr,
    output logic [word_width-1:0] dram_w_data,
    output logic [3:0]            glb_re,
    output logic [addr_width-1:0] glb_r_addr,
    output logic [3:0]            glb_we,
    output logic [addr_width-1:0] glb_w_addr,
    output logic [word_width-1:0] glb_w_data,
    output logic                  finish,
    output logic                  done
);
    logic drain;       // every group loaded, next pass empties the opsums
    logic last_group;

    assign last_group = group_base + ch_group >= num_ch;
    assign step       = phase inside {ifmap_write, filter_write, bias_write, opsum_clear};
    assign finish     = phase == pass_end && !drain;
    assign done       = phase == pass_end && drain;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= idle;
            drain      <= 1'b0;
            group_base <= '0;
            dram_we    <= 1'b0;
            glb_re     <= '0;
            glb_we     <= '0;
        end else begin
            case (phase)
                idle: begin
                    if (start)
                        phase <= drain ? opsum_read : ifmap_read;
                end
                ifmap_read: begin
                    glb_we <= '0;  // drops the previous write
                    phase  <= ifmap_write;
                end
                ifmap_write: begin
                    glb_we <= strobe_byte;
                    phase  <= last ? filter_read : ifmap_read;
                end
                filter_read: begin
                    glb_we <= '0;
                    phase  <= filter_write;
                end
                filter_write: begin
                    glb_we <= strobe_byte;
                    phase  <= last ? bias_read : filter_read;
                end
                bias_read: begin
                    glb_we <= '0;
                    phase  <= bias_write;
                end
                bias_write: begin
                    glb_we <= strobe_word;
                    phase  <= last ? pass_end : bias_read;
                end
                opsum_read: begin
                    glb_we <= '0;
                    glb_re <= strobe_word;
                    phase  <= opsum_wait;
                end
                opsum_wait: begin
                    glb_re <= '0;  // data shows up next cycle
                    phase  <= opsum_write;
                end
                opsum_write: begin
                    dram_we <= 1'b1;
                    phase   <= opsum_clear;
                end
                opsum_clear: begin
                    dram_we <= 1'b0;
                    glb_we  <= strobe_word;  // zero the word just copied
                    phase   <= last ? pass_end : opsum_read;
                end
                pass_end: begin
                    glb_we <= '0;
                    phase  <= idle;
                    if (drain) begin
                        drain      <= 1'b0;
                        group_base <= '0;
                    end else if (last_group) begin
                        drain <= 1'b1;
                    end else begin
                        group_base <= group_base + ch_group;
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (phase)
            ifmap_read, filter_read, bias_read: dram_addr <= dram_addr_next;
            ifmap_write, filter_write, bias_write: begin
                glb_w_addr <= glb_addr_next;
                glb_w_data <= dram_r_data;  // byte strobe keeps only the low byte
            end
            opsum_read: glb_r_addr <= glb_addr_next;
            opsum_write: begin
                dram_addr   <= dram_addr_next;
                dram_w_data <= glb_r_data;
            end
            opsum_clear: begin
                glb_w_addr <= glb_addr_next;
                glb_w_data <= '0;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/tiling_top.sv
`timescale 1ns/1ps

module tiling_top import tiling_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output logic                  finish,
    output logic                  done,
    input  logic [31:0]           mapping_param,
    input  logic [31:0]           shape_param1,
    input  logic [31:0]           shape_param2,
    input  logic [addr_width-1:0] dram_ifmap_base_addr,
    input  logic [addr_width-1:0] dram_filter_base_addr,
    input  logic [addr_width-1:0] dram_bias_base_addr,
    input  logic [addr_width-1:0] dram_opsum_base_addr,
    input  logic [addr_width-1:0] glb_ifmap_base_addr,
    input  logic [addr_width-1:0] glb_filter_base_addr,
    input  logic [addr_width-1:0] glb_bias_base_addr,
    input  logic [addr_width-1:0] glb_opsum_base_addr,
    output logic                  dram_we,
    output logic [addr_width-1:0] dram_addr,
    output logic [word_width-1:0] dram_w_data,
    input  logic [word_width-1:0] dram_r_data,
    output logic [3:0]            glb_re,
    output logic [addr_width-1:0] glb_r_addr,
    input  logic [word_width-1:0] glb_r_data,
    output logic [3:0]            glb_we,
    output logic [addr_width-1:0] glb_w_addr,
    output logic [word_width-1:0] glb_w_data
);
    logic [dim_width-1:0]  pad_w, pad_h, ch_group, num_ch, num_filt;
    logic [dim_width-1:0]  filt_h, filt_w, out_h, out_w;
    logic [dim_width-1:0]  row, col, ch, filt, group_base;
    logic [addr_width-1:0] dram_addr_next, glb_addr_next;
    phase_t                phase;
    logic                  step;
    logic                  last;

    shape_decode u_shape_decode (
        .mapping_param, .shape_param1, .shape_param2,
        .pad_w, .pad_h, .ch_group, .num_ch, .num_filt,
        .filt_h, .filt_w, .out_h, .out_w
    );

    index_walker u_index_walker (
        .clk, .rst, .phase, .step, .group_base,
        .pad_w, .pad_h, .ch_group, .num_filt, .filt_h, .filt_w, .out_h, .out_w,
        .row, .col, .ch, .filt, .last
    );

    addr_calc u_addr_calc (
        .phase, .row, .col, .ch, .filt, .group_base,
        .pad_w, .ch_group, .num_ch, .num_filt, .filt_h, .filt_w, .out_w,
        .dram_ifmap_base_addr, .dram_filter_base_addr,
        .dram_bias_base_addr, .dram_opsum_base_addr,
        .glb_ifmap_base_addr, .glb_filter_base_addr,
        .glb_bias_base_addr, .glb_opsum_base_addr,
        .dram_addr_next, .glb_addr_next
    );

    tile_fsm u_tile_fsm (
        .clk, .rst, .start, .last, .num_ch, .ch_group,
        .dram_addr_next, .glb_addr_next, .dram_r_data, .glb_r_data,
        .phase, .step, .group_base,
        .dram_we, .dram_addr, .dram_w_data,
        .glb_re, .glb_r_addr, .glb_we, .glb_w_addr, .glb_w_data,
        .finish, .done
    );

endmodule

// File: dv/tiling_checker.sv
`timescale 1ns/1ps

`include "tiling_defs.svh"

module tiling_checker import tiling_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mapping_param,
    input  logic [31:0] shape_param1,
    input  logic [31:0] shape_param2,
    input  logic [31:0] dram_ifmap_base_addr,
    input  logic [31:0] dram_filter_base_addr,
    input  logic [31:0] dram_bias_base_addr,
    input  logic [31:0] dram_opsum_base_addr,
    input  logic [31:0] glb_ifmap_base_addr,
    input  logic [31:0] glb_filter_base_addr,
    input  logic [31:0] glb_bias_base_addr,
    input  logic [31:0] glb_opsum_base_addr,
    input  logic        dram_we,
    input  logic [31:0] dram_addr,
    input  logic [31:0] dram_w_data,
    input  logic [3:0]  glb_re,
    input  logic [31:0] glb_r_addr,
    input  logic [3:0]  glb_we,
    input  logic [31:0] glb_w_addr,
    input  logic [31:0] glb_w_data,
    input  logic        finish,
    input  logic        done,
    output int          error_count
);
    // expected writes in issue order
    logic [31:0] glb_addr_q[$];
    logic [3:0]  glb_we_q[$];
    logic [31:0] glb_data_q[$];
    logic [31:0] glb_rd_q[$];
    logic [31:0] dram_addr_q[$];
    logic [31:0] dram_data_q[$];
    int unsigned pad, stride, fh, fw, nc, nf;
    int unsigned pw, ph, grp, oh, ow;
    int          finish_cnt = 0;
    int          done_cnt = 0;
    logic        draining = 1'b0;

    initial error_count = 0;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic decode_shape();
        int unsigned in_w;
        int unsigned in_h;
        pad    = shape_param1[`tl_sh_pad_hi:`tl_sh_pad_lo];
        stride = shape_param1[`tl_sh_u_hi:`tl_sh_u_lo];
        fh     = shape_param1[`tl_sh_r_hi:`tl_sh_r_lo];
        fw     = shape_param1[`tl_sh_s_hi:`tl_sh_s_lo];
        nc     = shape_param1[`tl_sh_c_hi:`tl_sh_c_lo];
        nf     = shape_param1[`tl_sh_m_hi:`tl_sh_m_lo];
        in_w   = shape_param2[`tl_sh_w_hi:`tl_sh_w_lo];
        in_h   = shape_param2[`tl_sh_h_hi:`tl_sh_h_lo];
        grp    = mapping_param[`tl_map_q_hi:`tl_map_q_lo]
               * mapping_param[`tl_map_r_hi:`tl_map_r_lo];
        pw     = in_w + 2 * pad;
        ph     = in_h + 2 * pad;
        ow     = (in_w - fw + 2 * pad) / stride + 1;
        oh     = (in_h - fh + 2 * pad) / stride + 1;
    endtask

    function automatic logic [31:0] dram_word(input int unsigned a);  // little endian
        return {tiling_tb.dram_mem[a + 3], tiling_tb.dram_mem[a + 2],
                tiling_tb.dram_mem[a + 1], tiling_tb.dram_mem[a]};
    endfunction

    task automatic push_glb(input logic [31:0] a, input logic [3:0] we, input logic [31:0] d);
        glb_addr_q.push_back(a);
        glb_we_q.push_back(we);
        glb_data_q.push_back(d);
    endtask

    task automatic expect_input_pass(input int unsigned group_base);
        int unsigned k;
        int unsigned a;
        decode_shape();
        draining = 1'b0;
        k = 0;
        for (int unsigned y = 0; y < ph; y++)
            for (int unsigned x = 0; x < pw; x++)
                for (int unsigned c = 0; c < grp; c++) begin
                    a = dram_ifmap_base_addr + (y * pw + x) * nc + group_base + c;
                    push_glb(glb_ifmap_base_addr + k, strobe_byte, {24'h0, tiling_tb.dram_mem[a]});
                    k++;
                end
        k = 0;  // filter buffer is dense in its own order
        for (int unsigned f = 0; f < nf; f++)
            for (int unsigned y = 0; y < fh; y++)
                for (int unsigned x = 0; x < fw; x++)
                    for (int unsigned c = 0; c < grp; c++) begin
                        a = dram_filter_base_addr + (y * fw + x) * nc * nf
                          + (group_base + c) * nf + f;
                        push_glb(glb_filter_base_addr + k, strobe_byte,
                                 {24'h0, tiling_tb.dram_mem[a]});
                        k++;
                    end
        for (int unsigned f = 0; f < nf; f++)
            push_glb(glb_bias_base_addr + 4 * f, strobe_word,
                     dram_word(dram_bias_base_addr + 4 * f));
    endtask

    // filter innermost, so the opsum words are consecutive in visiting order
    task automatic expect_drain();
        logic [31:0] g;
        decode_shape();
        draining = 1'b1;
        for (int unsigned k = 0; k < oh * ow * nf; k++) begin
            g = glb_opsum_base_addr + 4 * k;
            glb_rd_q.push_back(g);
            dram_addr_q.push_back(dram_opsum_base_addr + 4 * k);
            dram_data_q.push_back({tiling_tb.glb_mem[g + 3], tiling_tb.glb_mem[g + 2],
                                   tiling_tb.glb_mem[g + 1], tiling_tb.glb_mem[g]});
            push_glb(g, strobe_word, 32'h0);
        end
    endtask

    task automatic check_idle_outputs();
        compare_value("dram_we", 32'h0, {31'h0, dram_we});
        compare_value("glb_re", 32'h0, {28'h0, glb_re});
        compare_value("glb_we", 32'h0, {28'h0, glb_we});
        compare_value("finish", 32'h0, {31'h0, finish});
        compare_value("done", 32'h0, {31'h0, done});
    endtask

    task automatic check_pass_complete();
        if (glb_addr_q.size() != 0 || glb_rd_q.size() != 0 || dram_addr_q.size() != 0) begin
            error_count++;
            $display("%0t: pass ended with %0d GLB writes, %0d GLB reads, %0d DRAM writes missing",
                     $time, glb_addr_q.size(), glb_rd_q.size(), dram_addr_q.size());
        end
        glb_addr_q.delete();
        glb_we_q.delete();
        glb_data_q.delete();
        glb_rd_q.delete();
        dram_addr_q.delete();
        dram_data_q.delete();
    endtask

    task automatic check_row_end(input int unsigned passes);
        compare_value("finish count", passes, finish_cnt);
        compare_value("done count", 32'd1, done_cnt);
        finish_cnt = 0;
        done_cnt   = 0;
    endtask

    always @(negedge clk) begin
        logic [31:0] mask;
        if (!rst) begin
            if (glb_re != 4'h0) begin
                if (glb_rd_q.size() == 0) begin
                    error_count++;
                    $display("%0t: GLB read from %h when none was expected", $time, glb_r_addr);
                end else begin
                    compare_value("glb_re", {28'h0, strobe_word}, {28'h0, glb_re});
                    compare_value("glb_r_addr", glb_rd_q.pop_front(), glb_r_addr);
                end
            end
            if (glb_we != 4'h0) begin
                if (glb_addr_q.size() == 0) begin
                    error_count++;
                    $display("%0t: GLB write to %h when none was expected", $time, glb_w_addr);
                end else begin
                    mask = {{8{glb_we_q[0][3]}}, {8{glb_we_q[0][2]}},
                            {8{glb_we_q[0][1]}}, {8{glb_we_q[0][0]}}};  // bytes that count
                    compare_value("glb_w_addr", glb_addr_q.pop_front(), glb_w_addr);
                    compare_value("glb_we", {28'h0, glb_we_q.pop_front()}, {28'h0, glb_we});
                    compare_value("glb_w_data", glb_data_q.pop_front() & mask, glb_w_data & mask);
                end
            end
            if (dram_we) begin
                if (dram_addr_q.size() == 0) begin
                    error_count++;
                    $display("%0t: DRAM write to %h when none was expected", $time, dram_addr);
                end else begin
                    compare_value("dram_addr", dram_addr_q.pop_front(), dram_addr);
                    compare_value("dram_w_data", dram_data_q.pop_front(), dram_w_data);
                end
            end
            if (finish) begin
                finish_cnt++;
                if (draining) begin
                    error_count++;
                    $display("%0t: finish pulsed during the drain pass", $time);
                end
            end
            if (done) begin
                done_cnt++;
                if (!draining) begin
                    error_count++;
                    $display("%0t: done pulsed during an input pass", $time);
                end
            end
        end
    end

endmodule

// File: dv/tiling_tb.sv
`timescale 1ns/1ps

`include "tiling_defs.svh"

module tiling_tb;

    localparam int mem_bytes    = 16384;
    localparam int pass_timeout = 20000;  // cycles

    // columns: pad, u, r, s, c, m, w, h, then q and r of the mapping
    int unsigned shape_tbl [2][10] = '{
        '{1, 1, 3, 3, 4, 2, 4, 4, 1, 2},
        '{2, 2, 2, 3, 9, 3, 5, 3, 3, 1}
    };
    // ifmap, filter, bias, opsum
    int unsigned dram_base_tbl [2][4] = '{
        '{32'h0000, 32'h1000, 32'h2000, 32'h3000},
        '{32'h0100, 32'h1200, 32'h2040, 32'h3100}
    };
    int unsigned glb_base_tbl [2][4] = '{
        '{32'h0000, 32'h0400, 32'h0800, 32'h0c00},
        '{32'h0010, 32'h0420, 32'h0880, 32'h0c40}
    };
    int unsigned passes_tbl [2] = '{2, 3};  // C / (q*r)

    logic        clk, rst, start, finish, done;
    logic [31:0] mapping_param, shape_param1, shape_param2;
    logic [31:0] dram_ifmap_base_addr, dram_filter_base_addr;
    logic [31:0] dram_bias_base_addr, dram_opsum_base_addr;
    logic [31:0] glb_ifmap_base_addr, glb_filter_base_addr;
    logic [31:0] glb_bias_base_addr, glb_opsum_base_addr;
    logic        dram_we;
    logic [31:0] dram_addr, dram_w_data, dram_r_data;
    logic [3:0]  glb_re, glb_we;
    logic [31:0] glb_r_addr, glb_r_data, glb_w_addr, glb_w_data;
    int          error_count;
    logic [7:0]  dram_mem [mem_bytes];
    logic [7:0]  glb_mem [mem_bytes];

    tiling_top u_dut (.*);

    tiling_checker u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // dram answers in the same cycle
    assign dram_r_data = $isunknown(dram_addr) ? 32'h0 :
        {dram_mem[dram_addr[13:0] + 14'd3], dram_mem[dram_addr[13:0] + 14'd2],
         dram_mem[dram_addr[13:0] + 14'd1], dram_mem[dram_addr[13:0]]};

    always @(posedge clk) begin
        if (dram_we)
            for (int b = 0; b < 4; b++)
                dram_mem[dram_addr[13:0] + 14'(b)] <= dram_w_data[8*b +: 8];
        for (int b = 0; b < 4; b++)
            if (glb_we[b])
                glb_mem[glb_w_addr[13:0] + 14'(b)] <= glb_w_data[8*b +: 8];
        if (glb_re != 4'h0)  // one cycle read latency
            glb_r_data <= {glb_mem[glb_r_addr[13:0] + 14'd3], glb_mem[glb_r_addr[13:0] + 14'd2],
                           glb_mem[glb_r_addr[13:0] + 14'd1], glb_mem[glb_r_addr[13:0]]};
    end

    function automatic logic [31:0] field_bits(input int unsigned value, input int hi,
                                               input int lo);
        logic [31:0] mask;
        mask = (32'h1 << (hi - lo + 1)) - 32'h1;
        return (value & mask) << lo;
    endfunction

    task automatic apply_row(input int i);
        @(negedge clk);
        mapping_param = field_bits(shape_tbl[i][5], `tl_map_m_hi, `tl_map_m_lo)
                      | field_bits(shape_tbl[i][8], `tl_map_q_hi, `tl_map_q_lo)
                      | field_bits(shape_tbl[i][9], `tl_map_r_hi, `tl_map_r_lo);
        shape_param1  = field_bits(shape_tbl[i][0], `tl_sh_pad_hi, `tl_sh_pad_lo)
                      | field_bits(shape_tbl[i][1], `tl_sh_u_hi, `tl_sh_u_lo)
                      | field_bits(shape_tbl[i][2], `tl_sh_r_hi, `tl_sh_r_lo)
                      | field_bits(shape_tbl[i][3], `tl_sh_s_hi, `tl_sh_s_lo)
                      | field_bits(shape_tbl[i][4], `tl_sh_c_hi, `tl_sh_c_lo)
                      | field_bits(shape_tbl[i][5], `tl_sh_m_hi, `tl_sh_m_lo);
        shape_param2  = field_bits(shape_tbl[i][6], `tl_sh_w_hi, `tl_sh_w_lo)
                      | field_bits(shape_tbl[i][7], `tl_sh_h_hi, `tl_sh_h_lo);
        dram_ifmap_base_addr  = dram_base_tbl[i][0];
        dram_filter_base_addr = dram_base_tbl[i][1];
        dram_bias_base_addr   = dram_base_tbl[i][2];
        dram_opsum_base_addr  = dram_base_tbl[i][3];
        glb_ifmap_base_addr   = glb_base_tbl[i][0];
        glb_filter_base_addr  = glb_base_tbl[i][1];
        glb_bias_base_addr    = glb_base_tbl[i][2];
        glb_opsum_base_addr   = glb_base_tbl[i][3];
    endtask

    task automatic fill_memories(input int unsigned opsum_base);
        logic [31:0] word;
        for (int i = 0; i < mem_bytes; i++)
            dram_mem[i] = 8'($urandom);
        for (int i = 0; i < 256; i++) begin  // covers the largest opsum plane
            word = $urandom;
            for (int b = 0; b < 4; b++)
                glb_mem[opsum_base + 4 * i + b] = word[8*b +: 8];
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_pass_end(output logic ok);
        int cyc;
        cyc = 0;
        while (!(finish || done) && cyc < pass_timeout) begin
            @(negedge clk);
            cyc++;
        end
        ok = finish || done;
        if (!ok)
            $display("%0t: no finish or done within %0d cycles after start", $time, pass_timeout);
    endtask

    initial begin
        int unsigned grp;
        int          tb_errors;
        logic        ok;
        void'($urandom(32'h3c35f8ce));
        tb_errors = 0;
        ok        = 1'b1;
        rst = 1'b1;
        start = 1'b0;
        mapping_param = '0;
        shape_param1  = '0;
        shape_param2  = '0;
        dram_ifmap_base_addr  = '0;
        dram_filter_base_addr = '0;
        dram_bias_base_addr   = '0;
        dram_opsum_base_addr  = '0;
        glb_ifmap_base_addr   = '0;
        glb_filter_base_addr  = '0;
        glb_bias_base_addr    = '0;
        glb_opsum_base_addr   = '0;
        glb_r_data = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            u_chk.check_idle_outputs();
        end

        // second row follows done with no reset in between
        for (int i = 0; i < 2 && ok; i++) begin
            apply_row(i);
            fill_memories(glb_base_tbl[i][3]);
            grp = shape_tbl[i][8] * shape_tbl[i][9];
            for (int unsigned p = 0; p <= passes_tbl[i] && ok; p++) begin
                if (p < passes_tbl[i])
                    u_chk.expect_input_pass(p * grp);
                else
                    u_chk.expect_drain();
                pulse_start();
                wait_pass_end(ok);
                if (!ok)
                    tb_errors++;
                @(negedge clk);  // last write seen by the checker
                u_chk.check_pass_complete();
            end
            if (ok)
                u_chk.check_row_end(passes_tbl[i]);
        end

        $display("errors: %0d in checker, %0d in testbench", error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tiling.f
+incdir+include
logic/tiling_pkg.sv
logic/shape_decode.sv
logic/index_walker.sv
logic/addr_calc.sv
logic/tile_fsm.sv
logic/tiling_top.sv
dv/tiling_checker.sv
dv/tiling_tb.sv

// File: Bender.yml
package:
  name: tiling

sources:
  - include_dirs:
      - include
    files:
      - logic/tiling_pkg.sv
      - logic/shape_decode.sv
      - logic/index_walker.sv
      - logic/addr_calc.sv
      - logic/tile_fsm.sv
      - logic/tiling_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tiling_checker.sv
      - dv/tiling_tb.sv
